//--- Makefile
# Verilator build of the merge stream testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= merge_stream_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation exits non-zero on any failure, so make fails with it
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+rtl
rtl/stream_fmt_pkg.sv
rtl/merge_ctrl_pkg.sv
rtl/result_latch.sv
rtl/frame_sequencer.sv
rtl/word_merger.sv
rtl/merge_stream.sv
verification/merge_stream_tb.sv

//--- rtl/frame_sequencer.sv
`default_nettype none
`timescale 1ns/1ns

`include "merge_defs.svh"

// follows the framing of the bypass record one accepted word at a time
// and tells the merger which part of the record the next word belongs to
module frame_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         take,
    input  stream_fmt_pkg::stream_word_t s2i_data,
    output merge_ctrl_pkg::rec_phase_t   phase,
    output logic                         rec_done
);

    import merge_ctrl_pkg::*;

    sec_count_t cnt;
    sec_count_t cnt_nxt;
    sec_count_t hdr_len;
    sec_count_t hdr_words;
    rec_phase_t phase_nxt;
    logic       cnt_last;

    //////////////////////////////////////////////////
    // header length and word count
    //////////////////////////////////////////////////

    // the length field is read with the width of the section it opens
    always_comb begin
        if (phase == HDR_T) begin
            hdr_len = sec_count_t'(s2i_data[`T_POS_W-1:0]);
        end else begin
            hdr_len = sec_count_t'(s2i_data[`Q_POS_W-1:0]);
        end
    end

    // words = ceil(len / bases per word) which is zero for an empty section
    assign hdr_words = (hdr_len + sec_count_t'(`BASES_PER_TX - 1)) >> `LOG_BASES_PER_TX;

    assign cnt_last = (cnt == sec_count_t'(1));

    //////////////////////////////////////////////////
    // next phase and count
    //////////////////////////////////////////////////

    always_comb begin
        phase_nxt = phase;
        cnt_nxt   = cnt;
        case (phase)
            HDR_Q: begin
                // an empty query skips straight on to the target header
                cnt_nxt   = hdr_words;
                phase_nxt = (hdr_words == '0) ? HDR_T : DATA_Q;
            end
            DATA_Q: begin
                cnt_nxt = cnt - sec_count_t'(1);
                if (cnt_last) begin
                    phase_nxt = HDR_T;
                end
            end
            HDR_T: begin
                // an empty target goes straight on to the extra words
                if (hdr_words == '0) begin
                    cnt_nxt   = sec_count_t'(`NUM_EXTRA_TX);
                    phase_nxt = EXTRA;
                end else begin
                    cnt_nxt   = hdr_words;
                    phase_nxt = DATA_T;
                end
            end
            DATA_T: begin
                if (cnt_last) begin
                    cnt_nxt   = sec_count_t'(`NUM_EXTRA_TX);
                    phase_nxt = EXTRA;
                end else begin
                    cnt_nxt = cnt - sec_count_t'(1);
                end
            end
            EXTRA: begin
                cnt_nxt = cnt - sec_count_t'(1);
                if (cnt_last) begin
                    phase_nxt = Q_BASE;
                end
            end
            // the three tail words are one take each
            Q_BASE: phase_nxt = T_BASE;
            T_BASE: phase_nxt = G_SCORE;
            G_SCORE: phase_nxt = HDR_Q;
            default: phase_nxt = HDR_Q;
        endcase
    end

    // everything moves only on an accepted bypass word, so back-pressure
    // on the output freezes the walk as well
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= HDR_Q;
            cnt   <= '0;
        end else if (take) begin
            phase <= phase_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // the last word of the record releases the held result
    assign rec_done = take && (phase == G_SCORE);

    a_phase_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(phase) &&
        (phase inside {HDR_Q, DATA_Q, HDR_T, DATA_T, EXTRA, Q_BASE, T_BASE, G_SCORE}));

    // a counting phase is only ever entered with at least one word left
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        take && (phase inside {DATA_Q, DATA_T, EXTRA}) |-> cnt != '0);

endmodule

`default_nettype wire

//--- rtl/merge_ctrl_pkg.sv
`default_nettype none

`include "merge_defs.svh"

// control types for walking one bypass record
package merge_ctrl_pkg;

    // where we are in the record, in the order the words arrive
    // every encoding of the three bits is a real phase
    typedef enum logic [2:0] {
        HDR_Q   = 3'd0,
        DATA_Q  = 3'd1,
        HDR_T   = 3'd2,
        DATA_T  = 3'd3,
        EXTRA   = 3'd4,
        Q_BASE  = 3'd5,
        T_BASE  = 3'd6,
        G_SCORE = 3'd7
    } rec_phase_t;

    // words left in the current section
    // a 10 bit length rounds up to at most 16 words, the extra width
    // keeps the rounding add from wrapping
    typedef logic [`CNT_W-1:0] sec_count_t;

endpackage

`default_nettype wire

//--- rtl/merge_defs.svh
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

//////////////////////////////////////////////////
// stream and field widths
//////////////////////////////////////////////////

`define STREAM_W            128
`define HALF_W              64
`define SCORE_W             9
`define Q_POS_W             10
`define T_POS_W             10

// one base is packed into two bits on the bypass stream
`define BASE_W              2
`define BASES_PER_TX        (`STREAM_W / `BASE_W)
`define LOG_BASES_PER_TX    6

// words of alignment parameters after the target data
`define NUM_EXTRA_TX        3

// the local score goes into the query header at this bit
`define HDR_SCORE_LSB       16

// enough for the longest section plus the rounding term
`define CNT_W               11

//////////////////////////////////////////////////
// result word layout with the global score at the bottom
//////////////////////////////////////////////////

`define RES_GLB_SCORE_LSB   0
`define RES_GLB_T_BASE_LSB  (`RES_GLB_SCORE_LSB + `SCORE_W)
`define RES_LOC_SCORE_LSB   (`RES_GLB_T_BASE_LSB + `T_POS_W)
`define RES_LOC_T_BASE_LSB  (`RES_LOC_SCORE_LSB + `SCORE_W)
`define RES_LOC_Q_BASE_LSB  (`RES_LOC_T_BASE_LSB + `T_POS_W)

`endif

//--- rtl/merge_stream.sv
`default_nettype none
`timescale 1ns/1ns

// merges the alignment result stream into the bypass record stream
// one result word per record, one output word per bypass word
module merge_stream (
    input  logic                         clk,
    input  logic                         rst,

    // alignment results
    input  logic                         s1i_valid,
    output logic                         s1i_rdy,
    input  stream_fmt_pkg::stream_word_t s1i_data,

    // records held aside in the bypass path
    input  logic                         s2i_valid,
    output logic                         s2i_rdy,
    input  stream_fmt_pkg::stream_word_t s2i_data,

    // merged record
    output logic                         s1o_valid,
    input  logic                         s1o_rdy,
    output stream_fmt_pkg::stream_word_t s1o_data
);

    import stream_fmt_pkg::*;
    import merge_ctrl_pkg::*;

    // result fields held for the record in flight
    logic       held;
    score_t     loc_score;
    score_t     glb_score;
    q_pos_t     loc_q_base;
    t_pos_t     loc_t_base;
    t_pos_t     glb_t_base;

    // record walk
    logic       take;
    logic       rec_done;
    rec_phase_t phase;

    result_latch u_result_latch (
        .clk        (clk),
        .rst        (rst),
        .s1i_valid  (s1i_valid),
        .s1i_data   (s1i_data),
        .rec_done   (rec_done),
        .s1i_rdy    (s1i_rdy),
        .held       (held),
        .loc_score  (loc_score),
        .loc_q_base (loc_q_base),
        .loc_t_base (loc_t_base),
        .glb_t_base (glb_t_base),
        .glb_score  (glb_score)
    );

    frame_sequencer u_frame_sequencer (
        .clk      (clk),
        .rst      (rst),
        .take     (take),
        .s2i_data (s2i_data),
        .phase    (phase),
        .rec_done (rec_done)
    );

    word_merger u_word_merger (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .held       (held),
        .loc_score  (loc_score),
        .glb_score  (glb_score),
        .loc_q_base (loc_q_base),
        .loc_t_base (loc_t_base),
        .glb_t_base (glb_t_base),
        .s2i_valid  (s2i_valid),
        .s2i_data   (s2i_data),
        .s1o_rdy    (s1o_rdy),
        .s2i_rdy    (s2i_rdy),
        .take       (take),
        .s1o_valid  (s1o_valid),
        .s1o_data   (s1o_data)
    );

endmodule

`default_nettype wire

//--- rtl/result_latch.sv
`default_nettype none
`timescale 1ns/1ns

`include "merge_defs.svh"

// takes one result word per record and keeps its fields until the
// bypass record that belongs to it has gone out
module result_latch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        s1i_valid,
    input  stream_fmt_pkg::stream_word_t s1i_data,
    input  logic                        rec_done,
    output logic                        s1i_rdy,
    output logic                        held,
    output stream_fmt_pkg::score_t      loc_score,
    output stream_fmt_pkg::q_pos_t      loc_q_base,
    output stream_fmt_pkg::t_pos_t      loc_t_base,
    output stream_fmt_pkg::t_pos_t      glb_t_base,
    output stream_fmt_pkg::score_t      glb_score
);

    import stream_fmt_pkg::*;

    //////////////////////////////////////////////////
    // unpack the result word
    //////////////////////////////////////////////////

    score_t in_loc_score;
    score_t in_glb_score;
    q_pos_t in_loc_q_base;
    t_pos_t in_loc_t_base;
    t_pos_t in_glb_t_base;
    logic   held_nxt;

    assign in_glb_score  = s1i_data[`RES_GLB_SCORE_LSB +: `SCORE_W];
    assign in_glb_t_base = s1i_data[`RES_GLB_T_BASE_LSB +: `T_POS_W];
    assign in_loc_score  = s1i_data[`RES_LOC_SCORE_LSB +: `SCORE_W];
    assign in_loc_t_base = s1i_data[`RES_LOC_T_BASE_LSB +: `T_POS_W];
    assign in_loc_q_base = s1i_data[`RES_LOC_Q_BASE_LSB +: `Q_POS_W];

    //////////////////////////////////////////////////
    // hold flag and input ready
    //////////////////////////////////////////////////

    // a result is held from its accept until the G_SCORE word is taken
    always_comb begin
        held_nxt = held;
        if (rec_done) begin
            held_nxt = 1'b0;
        end else if (s1i_valid && s1i_rdy) begin
            held_nxt = 1'b1;
        end
    end

    // ready is the registered inverse of the next hold state, so it stays
    // low through reset and comes up on the first edge after it
    always_ff @(posedge clk) begin
        if (rst) begin
            held    <= 1'b0;
            s1i_rdy <= 1'b0;
        end else begin
            held    <= held_nxt;
            s1i_rdy <= !held_nxt;
        end
    end

    // the fields load on an accept and keep their value until the next one
    always_ff @(posedge clk) begin
        if (s1i_valid && s1i_rdy) begin
            loc_score  <= in_loc_score;
            loc_q_base <= in_loc_q_base;
            loc_t_base <= in_loc_t_base;
            glb_t_base <= in_glb_t_base;
            glb_score  <= in_glb_score;
        end
    end

    // the sequencer may only close a record that has a result behind it
    a_done_needs_held: assert property (@(posedge clk) disable iff (rst)
        rec_done |-> held);

    // the merger reads these fields across many cycles of one record
    a_fields_stable: assert property (@(posedge clk) disable iff (rst)
        held |=> !held ||
            $stable({loc_score, loc_q_base, loc_t_base, glb_t_base, glb_score}));

endmodule

`default_nettype wire

//--- rtl/stream_fmt_pkg.sv
`default_nettype none

`include "merge_defs.svh"

// word and field formats shared by the three streams
package stream_fmt_pkg;

    //////////////////////////////////////////////////
    // whole words
    //////////////////////////////////////////////////

    // one transfer on any of the streams
    typedef logic [`STREAM_W-1:0] stream_word_t;

    // the tail words are split into an upper and a lower half
    typedef logic [`HALF_W-1:0] half_word_t;

    //////////////////////////////////////////////////
    // result fields
    //////////////////////////////////////////////////

    // alignment scores are signed and may go negative for the global case
    typedef logic signed [`SCORE_W-1:0] score_t;

    // a base index into the query, also used for the query length
    typedef logic [`Q_POS_W-1:0] q_pos_t;

    // a base index into the target, also used for the target length
    typedef logic [`T_POS_W-1:0] t_pos_t;

    //////////////////////////////////////////////////
    // header fields
    //////////////////////////////////////////////////

    // the query header keeps its length in the low bits and picks up
    // the local score at HDR_SCORE_LSB on the way out
    // the target header carries its own length the same way and is
    // passed on as it is

endpackage

`default_nettype wire

//--- rtl/word_merger.sv
`default_nettype none
`timescale 1ns/1ns

`include "merge_defs.svh"

// output register of the merge, fed from the bypass word and the held
// result fields
module word_merger (
    input  logic                         clk,
    input  logic                         rst,
    input  merge_ctrl_pkg::rec_phase_t   phase,
    input  logic                         held,
    input  stream_fmt_pkg::score_t       loc_score,
    input  stream_fmt_pkg::score_t       glb_score,
    input  stream_fmt_pkg::q_pos_t       loc_q_base,
    input  stream_fmt_pkg::t_pos_t       loc_t_base,
    input  stream_fmt_pkg::t_pos_t       glb_t_base,
    input  logic                         s2i_valid,
    input  stream_fmt_pkg::stream_word_t s2i_data,
    input  logic                         s1o_rdy,
    output logic                         s2i_rdy,
    output logic                         take,
    output logic                         s1o_valid,
    output stream_fmt_pkg::stream_word_t s1o_data
);

    import stream_fmt_pkg::*;
    import merge_ctrl_pkg::*;

    logic         slot_free;
    q_pos_t       q_len;
    stream_word_t merged;

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    // the slot can take a word when it is empty or is being read now
    assign slot_free = !s1o_valid || s1o_rdy;

    // nothing is taken from the bypass stream until its result is here
    assign s2i_rdy = held && slot_free;
    assign take    = s2i_rdy && s2i_valid;

    //////////////////////////////////////////////////
    // word forming
    //////////////////////////////////////////////////

    assign q_len = s2i_data[`Q_POS_W-1:0];

    // scores are cast unsigned first so the halves zero extend
    always_comb begin
        case (phase)
            HDR_Q: merged = {{(`STREAM_W - `HDR_SCORE_LSB - `SCORE_W){1'b0}},
                             loc_score,
                             {(`HDR_SCORE_LSB - `Q_POS_W){1'b0}},
                             q_len};
            Q_BASE: merged = {half_word_t'(loc_q_base), s2i_data[`HALF_W-1:0]};
            T_BASE: merged = {half_word_t'(glb_t_base), half_word_t'(loc_t_base)};
            G_SCORE: merged = {s2i_data[`STREAM_W-1:`HALF_W],
                               half_word_t'($unsigned(glb_score))};
            // data, target header and extra words go through untouched
            default: merged = s2i_data;
        endcase
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1o_valid <= 1'b0;
        end else if (take) begin
            s1o_valid <= 1'b1;
        end else if (s1o_rdy) begin
            s1o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1o_data <= merged;
        end
    end

    // a stalled word must not change under the receiver
    a_data_held: assert property (@(posedge clk) disable iff (rst)
        s1o_valid && !s1o_rdy |=> $stable(s1o_data));

endmodule

`default_nettype wire

//--- verification/merge_stream_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "merge_defs.svh"

module merge_stream_tb;

    import stream_fmt_pkg::*;

    localparam int MAX_WORDS  = 64;
    localparam int WAIT_LIMIT = 200;

    logic         clk;
    logic         rst;
    logic         s1i_valid;
    logic         s1i_rdy;
    stream_word_t s1i_data;
    logic         s2i_valid;
    logic         s2i_rdy;
    stream_word_t s2i_data;
    logic         s1o_valid;
    logic         s1o_rdy;
    stream_word_t s1o_data;

    // raw file image, then the same content split per stream
    stream_word_t tdata [0:MAX_WORDS-1];
    stream_word_t res_q[$];
    stream_word_t byp_q[$];
    stream_word_t exp_q[$];
    // running total of bypass words at the end of each record
    int           rec_end[$];
    int           idle_gap[$];
    int           seed;
    int           bypass_taken;
    int           out_seen;

    merge_stream u_merge_stream (
        .clk       (clk),
        .rst       (rst),
        .s1i_valid (s1i_valid),
        .s1i_rdy   (s1i_rdy),
        .s1i_data  (s1i_data),
        .s2i_valid (s2i_valid),
        .s2i_rdy   (s2i_rdy),
        .s2i_data  (s2i_data),
        .s1o_valid (s1o_valid),
        .s1o_rdy   (s1o_rdy),
        .s1o_data  (s1o_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input stream_word_t got,
                              input stream_word_t want);
        if (got !== want) begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // a section of len bases fills ceil(len / bases per word) words
    function automatic int words_for(input stream_word_t len);
        return (int'(len) + `BASES_PER_TX - 1) / `BASES_PER_TX;
    endfunction

    //////////////////////////////////////////////////
    // data file
    //////////////////////////////////////////////////

    task automatic load_records();
        int n_rec;
        int p;
        int n;
        int r;
        int i;
        int total;
        $readmemh("verification/merge_stream_testdata.txt", tdata);
        n_rec = int'(tdata[0]);
        if (n_rec == 0) begin
            abort_run("the data file holds no records");
        end
        p     = 1;
        total = 0;
        for (r = 0; r < n_rec; r++) begin
            // both headers, the data words, the extra words and three tail words
            n = 2 + words_for(tdata[p+1]) + words_for(tdata[p+2]) + `NUM_EXTRA_TX + 3;
            if (p + 3 + 2 * n > MAX_WORDS) begin
                abort_run("the data file ends inside a record");
            end
            res_q.push_back(tdata[p]);
            for (i = 0; i < n; i++) begin
                byp_q.push_back(tdata[p + 3 + i]);
                exp_q.push_back(tdata[p + 3 + n + i]);
            end
            total += n;
            rec_end.push_back(total);
            p += 3 + 2 * n;
        end
    endtask

    //////////////////////////////////////////////////
    // stream drivers and output collector
    //////////////////////////////////////////////////

    // inputs change on the falling edge, handshakes are sampled 1 ns later
    task automatic drive_results();
        int r;
        int tries;
        for (r = 0; r < res_q.size(); r++) begin
            s1i_valid = 1'b1;
            s1i_data  = res_q[r];
            tries     = 0;
            #1;
            while (!s1i_rdy) begin
                @(negedge clk);
                #1;
                tries++;
                if (tries > WAIT_LIMIT) begin
                    abort_run("timeout waiting for s1i_rdy");
                end
            end
            // the next result is only accepted once the previous record is fully taken
            if (r > 0) begin
                check_word("bypass words taken before s1i_rdy",
                           stream_word_t'(bypass_taken), stream_word_t'(rec_end[r-1]));
            end
            @(negedge clk);
        end
        s1i_valid = 1'b0;
        s1i_data  = '0;
    endtask

    task automatic drive_bypass();
        int i;
        int tries;
        for (i = 0; i < byp_q.size(); i++) begin
            if (idle_gap[i] > 0) begin
                s2i_valid = 1'b0;
                s2i_data  = '0;
                repeat (idle_gap[i]) @(negedge clk);
            end
            s2i_valid = 1'b1;
            s2i_data  = byp_q[i];
            tries     = 0;
            #1;
            while (!s2i_rdy) begin
                @(negedge clk);
                #1;
                tries++;
                if (tries > WAIT_LIMIT) begin
                    abort_run("timeout waiting for s2i_rdy");
                end
            end
            bypass_taken++;
            @(negedge clk);
        end
        s2i_valid = 1'b0;
        s2i_data  = '0;
    endtask

    // every output transfer must match the next expected word in order
    task automatic collect_output();
        int tries;
        tries = 0;
        while (out_seen < exp_q.size()) begin
            s1o_rdy = (($random(seed) & 3) != 0);
            #1;
            if (s1o_valid && s1o_rdy) begin
                check_word($sformatf("s1o_data word %0d", out_seen), s1o_data,
                           exp_q[out_seen]);
                out_seen++;
                tries = 0;
            end else begin
                tries++;
                if (tries > WAIT_LIMIT) begin
                    abort_run("timeout waiting for an output word");
                end
            end
            @(negedge clk);
        end
        // keep the output open so that any extra word would show up
        s1o_rdy = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int g;
        int k;
        rst          = 1'b1;
        s1i_valid    = 1'b0;
        s1i_data     = '0;
        s2i_valid    = 1'b0;
        s2i_data     = '0;
        s1o_rdy      = 1'b0;
        seed         = 70;
        bypass_taken = 0;
        out_seen     = 0;
        load_records();
        // mostly back to back, now and then one or two idle cycles
        for (k = 0; k < byp_q.size(); k++) begin
            g = $random(seed) & 7;
            idle_gap.push_back((g < 3) ? g : 0);
        end

        repeat (5) @(negedge clk);
        rst = 1'b0;
        #1;
        check_word("s1i_rdy", stream_word_t'(s1i_rdy), stream_word_t'(1'b0));
        check_word("s1o_valid", stream_word_t'(s1o_valid), stream_word_t'(1'b0));
        check_word("s2i_rdy", stream_word_t'(s2i_rdy), stream_word_t'(1'b0));

        // with no input yet only s1i_rdy comes up, on the first edge out of reset
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            #1;
            check_word("s1i_rdy", stream_word_t'(s1i_rdy), stream_word_t'(1'b1));
            check_word("s1o_valid", stream_word_t'(s1o_valid), stream_word_t'(1'b0));
            check_word("s2i_rdy", stream_word_t'(s2i_rdy), stream_word_t'(1'b0));
        end
        @(negedge clk);

        fork
            drive_results();
            drive_bypass();
            collect_output();
        join

        // the stream is drained, nothing more may come out and a new result is welcome
        for (k = 0; k < 4; k++) begin
            #1;
            check_word("s1o_valid", stream_word_t'(s1o_valid), stream_word_t'(1'b0));
            check_word("s1i_rdy", stream_word_t'(s1i_rdy), stream_word_t'(1'b1));
            @(negedge clk);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/merge_stream_testdata.txt
// first word is the record count; each record: result word, query length, target length,
// then its bypass words, then the expected output words in the same order
2
// record 0: query of 1 base (1 word), target of 65 bases (2 words), negative global score
0000000000000000000067ab153f8bf3
001
041
a5a5a5a5a5a5a5a5a5a5a5a5a5a5fc01
0123456789abcdeffedcba9876543210
5a5a5a5a5a5a5a5a5a5a5a5a5a5a0041
11111111222222223333333344444444
55555555666666667777777788888888
0000000000000000000000000000e001
0000000000000000000000000000e002
0000000000000000000000000000e003
aaaaaaaaaaaaaaaabbbbbbbbbbbbbbbb
cccccccccccccccccccccccccccccccc
ddddddddddddddddeeeeeeeeeeeeeeee
00000000000000000000000000a70001
0123456789abcdeffedcba9876543210
5a5a5a5a5a5a5a5a5a5a5a5a5a5a0041
11111111222222223333333344444444
55555555666666667777777788888888
0000000000000000000000000000e001
0000000000000000000000000000e002
0000000000000000000000000000e003
000000000000019ebbbbbbbbbbbbbbbb
00000000000003c500000000000002b1
dddddddddddddddd00000000000001f3
// record 1: empty query (no data words), target of 64 bases (1 word)
00000000000000000000807ffff88005
000
040
fffffffffffffffffffffffffffffc00
00000000000000000000000000000040
f0e1d2c3b4a5968778695a4b3c2d1e0f
0000000000000000000000000000e011
0000000000000000000000000000e012
0000000000000000000000000000e013
12345678123456788765432187654321
77777777777777777777777777777777
abcdefabcdefabcd0123012301230123
000000000000000000000000001ff0000
00000000000000000000000000000040
f0e1d2c3b4a5968778695a4b3c2d1e0f
0000000000000000000000000000e011
0000000000000000000000000000e012
0000000000000000000000000000e013
00000000000002018765432187654321
000000000000004000000000000003ff
abcdefabcdefabcd0000000000000005
